// ==== verilog.f ====
verilog/ltsm_pkg.sv
verilog/sb_msg_pkg.sv
verilog/sb_rx_decoder.sv
verilog/ltsm_timers.sv
verilog/ltsm_sequencer.sv
verilog/sb_tx_framer.sv
verilog/link_training_top.sv
test/tb_clock.sv
test/tb_link_training.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the link training testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_link_training -f verilog.f \
    --Mdir obj_dir -o sim_link_training
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_link_training > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "all tests passed" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL: tests failed"
    exit 1
fi

// ==== test/tb_link_training.sv ====
`timescale 1ns/1ps

module tb_link_training import ltsm_pkg::*, sb_msg_pkg::*; ();

    localparam int RESET_DWELL   = RESET_DWELL_DEFAULT;
    localparam int STATE_TIMEOUT = 600;
    localparam int RETRY         = 100;
    localparam int NUM_TESTS     = 6;
    localparam int WATCHDOG_NS   = NUM_TESTS * 6 * STATE_TIMEOUT * 10;
    localparam int WAIT_LIMIT    = 4 * STATE_TIMEOUT;

    logic        clk_100MHz;
    logic        sys_reset;
    logic        test_reset;
    logic        dut_reset;
    logic        enable_i;
    logic        start_training_i;
    sb_msg_t     rx_msg_i;
    logic        rx_valid_i;
    logic        rx_ready_o;
    sb_msg_t     tx_msg_o;
    logic        tx_valid_o;
    logic        tx_ready_i;
    logic        link_active_o;
    ltsm_state_t train_state_o;

    string       test_name;
    int          test_errors;
    int          tests_run;
    int          tests_failing;
    integer      seed;
    logic        respond_en;
    logic        err_ok;
    logic        bp_en;
    // Model of the link as the partner sees it
    ltsm_state_t exp_state;
    logic [7:0]  exp_tag;
    logic [7:0]  partner_tag;
    int          xfer_count;
    int          err_seen;
    int          last_xfer_cycle;
    int          cycle;
    int          rx_sent;
    sb_msg_t     rx_q[$];
    logic        prev_stall;
    sb_msg_t     held_msg;

    assign dut_reset = sys_reset | test_reset;

    tb_clock u_tb_clock (
        .clk_100MHz_o (clk_100MHz),
        .reset_o      (sys_reset)
    );

    link_training_top #(
        .RESET_DWELL   (RESET_DWELL),
        .STATE_TIMEOUT (STATE_TIMEOUT),
        .RETRY         (RETRY)
    ) u_link_training_top (
        .clk_100MHz       (clk_100MHz),
        .reset            (dut_reset),
        .enable_i         (enable_i),
        .start_training_i (start_training_i),
        .rx_msg_i         (rx_msg_i),
        .rx_valid_i       (rx_valid_i),
        .rx_ready_o       (rx_ready_o),
        .tx_msg_o         (tx_msg_o),
        .tx_valid_o       (tx_valid_o),
        .tx_ready_i       (tx_ready_i),
        .link_active_o    (link_active_o),
        .train_state_o    (train_state_o)
    );

    // Parity bit chosen so the whole message XORs to zero
    function automatic sb_msg_t expected_msg(input sb_opcode_t  opcode,
                                             input ltsm_state_t state,
                                             input logic [7:0]  tag);
        sb_msg_t m;
        m.opcode = opcode;
        m.state  = state;
        m.tag    = tag;
        m.parity = 1'b0;
        m.parity = ^m;
        return m;
    endfunction

    function automatic ltsm_state_t next_train_state(input ltsm_state_t s);
        case (s)
            SBINIT:   return MBINIT;
            MBINIT:   return MBTRAIN;
            MBTRAIN:  return LINKINIT;
            LINKINIT: return ACTIVE;
            default:  return s;
        endcase
    endfunction

    task automatic check_msg(input string what, input sb_msg_t exp, input sb_msg_t act);
        if (act !== exp) begin
            $display("Mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
            test_errors = test_errors + 1;
        end
    endtask

    task automatic check_state(input string what, input ltsm_state_t exp,
                               input ltsm_state_t act);
        if (act !== exp) begin
            $display("Mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
            test_errors = test_errors + 1;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch %s %s: expected %b actual %b", test_name, what, exp, act);
            test_errors = test_errors + 1;
        end
    endtask

    task automatic report_error(input string what);
        $display("Error %s: %s", test_name, what);
        test_errors = test_errors + 1;
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run = tests_run + 1;
        if (test_errors != 0) begin
            tests_failing = tests_failing + 1;
            $display("test %s: FAIL with %0d errors", test_name, test_errors);
        end else begin
            $display("test %s: PASS", test_name);
        end
    endtask

    task automatic run_cycles(input int n);
        repeat (n) @(posedge clk_100MHz);
        #1;
    endtask

    task automatic apply_reset();
        @(posedge clk_100MHz);
        #1;
        test_reset       = 1'b1;
        start_training_i = 1'b0;
        respond_en       = 1'b0;
        err_ok           = 1'b0;
        bp_en            = 1'b0;
        run_cycles(8);
        test_reset = 1'b0;
    endtask

    task automatic wait_state(input ltsm_state_t target, input int limit);
        int n;
        n = 0;
        while (train_state_o != target && n < limit) begin
            @(negedge clk_100MHz);
            n = n + 1;
        end
        if (train_state_o != target) begin
            report_error($sformatf("state did not reach %h within %0d cycles", target, limit));
        end
    endtask

    task automatic wait_xfers(input int count, input int limit);
        int n;
        n = 0;
        while (xfer_count < count && n < limit) begin
            @(negedge clk_100MHz);
            n = n + 1;
        end
        if (xfer_count < count) begin
            report_error($sformatf("only %0d messages sent, waited for %0d", xfer_count, count));
        end
    endtask

    // Sends one partner message and checks that the state held
    task automatic send_and_hold(input sb_msg_t m, input string what);
        int target;
        int n;
        target = rx_sent + 1;
        n      = 0;
        rx_q.push_back(m);
        while (rx_sent < target && n < 50) begin
            @(negedge clk_100MHz);
            n = n + 1;
        end
        if (rx_sent < target) begin
            report_error($sformatf("%s was never accepted", what));
        end
        run_cycles(10);
        check_state(what, SBINIT, train_state_o);
    endtask

    initial begin : count_cycles
        cycle = 0;
        forever begin
            @(posedge clk_100MHz);
            cycle = cycle + 1;
        end
    end

    // Sampled at the falling edge ahead of the transferring rising edge
    initial begin : compare_tx
        sb_msg_t exp;
        exp_tag     = 8'd0;
        partner_tag = 8'd0;
        xfer_count  = 0;
        err_seen    = 0;
        prev_stall  = 1'b0;
        held_msg    = '0;
        forever begin
            @(negedge clk_100MHz);
            if (dut_reset) begin
                exp_tag    = 8'd0;
                xfer_count = 0;
                err_seen   = 0;
                prev_stall = 1'b0;
            end else begin
                if (prev_stall) begin
                    check_bit("tx_valid_o held", 1'b1, tx_valid_o);
                    check_msg("held tx_msg_o", held_msg, tx_msg_o);
                end
                prev_stall = tx_valid_o && !tx_ready_i;
                held_msg   = tx_msg_o;
                if (tx_valid_o && tx_ready_i) begin
                    if (err_ok) begin
                        exp = expected_msg(SB_ERR, TRAINERROR, exp_tag);
                    end else begin
                        exp = expected_msg(SB_REQ, exp_state, exp_tag);
                    end
                    check_msg("tx message", exp, tx_msg_o);
                    if (tx_msg_o.opcode == SB_ERR) begin
                        err_seen = err_seen + 1;
                    end
                    // Partner answers for the state it was asked about
                    if (respond_en && tx_msg_o.opcode == SB_REQ) begin
                        rx_q.push_back(expected_msg(SB_RESP, tx_msg_o.state, partner_tag));
                        partner_tag = partner_tag + 8'd1;
                    end
                    exp_tag         = exp_tag + 8'd1;
                    xfer_count      = xfer_count + 1;
                    last_xfer_cycle = cycle;
                end
            end
        end
    end

    initial begin : drive_rx
        sb_msg_t m;
        logic    done;
        rx_msg_i   = '0;
        rx_valid_i = 1'b0;
        rx_sent    = 0;
        exp_state  = SBINIT;
        forever begin
            @(posedge clk_100MHz);
            #1;
            if (dut_reset) begin
                exp_state = SBINIT;
                rx_q.delete();
            end else if (rx_q.size() != 0) begin
                m          = rx_q.pop_front();
                rx_msg_i   = m;
                rx_valid_i = 1'b1;
                done       = 1'b0;
                while (!done) begin
                    @(negedge clk_100MHz);
                    done = dut_reset || rx_ready_o;
                    @(posedge clk_100MHz);
                    #1;
                end
                rx_valid_i = 1'b0;
                rx_msg_i   = '0;
                // A clean response for the current state moves the link on
                if (!dut_reset && m.opcode == SB_RESP && m.state == exp_state && ^m == 1'b0) begin
                    exp_state = next_train_state(exp_state);
                end
                rx_sent = rx_sent + 1;
            end
        end
    end

    initial begin : drive_tx_ready
        int stretch;
        seed       = 32'h23bc8606;
        stretch    = 0;
        tx_ready_i = 1'b1;
        forever begin
            @(posedge clk_100MHz);
            #1;
            if (!bp_en) begin
                tx_ready_i = 1'b1;
                stretch    = 0;
            end else begin
                if (stretch == 0) begin
                    tx_ready_i = ~tx_ready_i;
                    stretch    = ($random(seed) & 7) + 1;
                end
                stretch = stretch - 1;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("tests failed");
        $finish;
    end

    initial begin : run_tests
        int      n;
        int      t1;
        sb_msg_t bad;
        test_reset       = 1'b0;
        enable_i         = 1'b0;
        start_training_i = 1'b0;
        respond_en       = 1'b0;
        err_ok           = 1'b0;
        bp_en            = 1'b0;
        tests_run        = 0;
        tests_failing    = 0;

        begin_test("reset_idle");
        wait (!dut_reset);
        @(negedge clk_100MHz);
        check_state("train_state_o", RESET, train_state_o);
        check_bit("tx_valid_o", 1'b0, tx_valid_o);
        check_bit("rx_ready_o", 1'b0, rx_ready_o);
        check_bit("link_active_o", 1'b0, link_active_o);
        run_cycles(1);
        enable_i = 1'b1;
        n        = 0;
        while (n < 3 * RESET_DWELL && train_state_o == RESET) begin
            @(negedge clk_100MHz);
            n = n + 1;
        end
        check_state("train_state_o with start low", RESET, train_state_o);
        end_test();

        begin_test("full_training");
        run_cycles(1);
        respond_en       = 1'b1;
        start_training_i = 1'b1;
        wait_state(ACTIVE, WAIT_LIMIT);
        check_bit("link_active_o", 1'b1, link_active_o);
        n = xfer_count;
        if (n != 4) begin
            report_error($sformatf("%0d requests sent instead of 4", n));
        end
        run_cycles(2 * RETRY);
        if (xfer_count != n) begin
            report_error("messages were sent after the link became active");
        end
        check_bit("tx_valid_o in ACTIVE", 1'b0, tx_valid_o);
        end_test();

        apply_reset();
        begin_test("rx_filtering");
        start_training_i = 1'b1;
        wait_xfers(1, WAIT_LIMIT);
        bad        = expected_msg(SB_RESP, SBINIT, 8'h40);
        bad.parity = ~bad.parity;
        send_and_hold(bad, "bad parity response");
        send_and_hold(expected_msg(SB_RESP, MBTRAIN, 8'h41), "wrong state response");
        send_and_hold(expected_msg(SB_REQ, SBINIT, 8'h42), "partner request");
        rx_q.push_back(expected_msg(SB_RESP, SBINIT, 8'h43));
        wait_state(MBINIT, 50);
        end_test();

        apply_reset();
        begin_test("retry");
        start_training_i = 1'b1;
        wait_xfers(1, WAIT_LIMIT);
        t1 = last_xfer_cycle;
        wait_xfers(2, WAIT_LIMIT);
        if (last_xfer_cycle - t1 < RETRY) begin
            report_error($sformatf("request re-sent after %0d cycles, minimum is %0d",
                                   last_xfer_cycle - t1, RETRY));
        end
        end_test();

        apply_reset();
        begin_test("timeout");
        start_training_i = 1'b1;
        wait_xfers(1, WAIT_LIMIT);
        // The state timeout cannot expire this early
        run_cycles(STATE_TIMEOUT - 8);
        err_ok = 1'b1;
        n      = 0;
        while (err_seen == 0 && n < WAIT_LIMIT) begin
            @(negedge clk_100MHz);
            n = n + 1;
        end
        if (err_seen == 0) begin
            report_error("no error message after the state timeout");
        end
        wait_state(RESET, 10);
        run_cycles(1);
        start_training_i = 1'b0;
        err_ok           = 1'b0;
        respond_en       = 1'b1;
        run_cycles(5);
        check_state("train_state_o after error", RESET, train_state_o);
        if (err_seen != 1) begin
            report_error($sformatf("%0d error messages sent instead of 1", err_seen));
        end
        start_training_i = 1'b1;
        wait_state(ACTIVE, WAIT_LIMIT);
        check_bit("link_active_o after restart", 1'b1, link_active_o);
        end_test();

        apply_reset();
        begin_test("back_pressure");
        respond_en       = 1'b1;
        bp_en            = 1'b1;
        start_training_i = 1'b1;
        wait_state(ACTIVE, WAIT_LIMIT);
        run_cycles(1);
        bp_en = 1'b0;
        check_bit("link_active_o", 1'b1, link_active_o);
        end_test();

        $display("summary: %0d run, %0d failing", tests_run, tests_failing);
        if (tests_failing == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_100MHz_o,
    output logic reset_o
);

    initial begin
        clk_100MHz_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk_100MHz_o = ~clk_100MHz_o;
        end
    end

    // Reset drops just after an edge, like the other inputs
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_100MHz_o);
        #1;
        reset_o = 1'b0;
    end

endmodule

// ==== verilog/link_training_top.sv ====
`timescale 1ns/1ps

module link_training_top import ltsm_pkg::*, sb_msg_pkg::*; #(
    parameter int RESET_DWELL   = RESET_DWELL_DEFAULT,
    parameter int STATE_TIMEOUT = STATE_TIMEOUT_DEFAULT,
    parameter int RETRY         = RETRY_DEFAULT
) (
    input  logic        clk_100MHz,
    input  logic        reset,
    input  logic        enable_i,
    input  logic        start_training_i,
    input  sb_msg_t     rx_msg_i,
    input  logic        rx_valid_i,
    output logic        rx_ready_o,
    output sb_msg_t     tx_msg_o,
    output logic        tx_valid_o,
    input  logic        tx_ready_i,
    output logic        link_active_o,
    output ltsm_state_t train_state_o
);

    logic        resp_valid;
    ltsm_state_t resp_state;
    logic        rx_enable;
    sb_req_t     req;
    logic        req_valid;
    logic        req_ready;
    logic        msg_sent;
    ltsm_state_t state;
    logic        state_change;
    logic        dwell_done;
    logic        state_timeout;
    logic        retry_due;

    assign train_state_o = state;

    sb_rx_decoder u_sb_rx_decoder (
        .clk_100MHz   (clk_100MHz),
        .reset        (reset),
        .rx_enable_i  (rx_enable),
        .rx_msg_i     (rx_msg_i),
        .rx_valid_i   (rx_valid_i),
        .rx_ready_o   (rx_ready_o),
        .resp_valid_o (resp_valid),
        .resp_state_o (resp_state)
    );

    ltsm_sequencer u_ltsm_sequencer (
        .clk_100MHz       (clk_100MHz),
        .reset            (reset),
        .enable_i         (enable_i),
        .start_training_i (start_training_i),
        .resp_valid_i     (resp_valid),
        .resp_state_i     (resp_state),
        .dwell_done_i     (dwell_done),
        .state_timeout_i  (state_timeout),
        .retry_due_i      (retry_due),
        .req_ready_i      (req_ready),
        .msg_sent_i       (msg_sent),
        .state_o          (state),
        .state_change_o   (state_change),
        .rx_enable_o      (rx_enable),
        .req_o            (req),
        .req_valid_o      (req_valid),
        .link_active_o    (link_active_o)
    );

    ltsm_timers #(
        .RESET_DWELL   (RESET_DWELL),
        .STATE_TIMEOUT (STATE_TIMEOUT),
        .RETRY         (RETRY)
    ) u_ltsm_timers (
        .clk_100MHz      (clk_100MHz),
        .reset           (reset),
        .state_i         (state),
        .state_change_i  (state_change),
        .msg_sent_i      (msg_sent),
        .dwell_done_o    (dwell_done),
        .state_timeout_o (state_timeout),
        .retry_due_o     (retry_due)
    );

    sb_tx_framer u_sb_tx_framer (
        .clk_100MHz  (clk_100MHz),
        .reset       (reset),
        .req_i       (req),
        .req_valid_i (req_valid),
        .tx_ready_i  (tx_ready_i),
        .req_ready_o (req_ready),
        .tx_msg_o    (tx_msg_o),
        .tx_valid_o  (tx_valid_o),
        .msg_sent_o  (msg_sent)
    );

endmodule

// ==== verilog/sb_tx_framer.sv ====
`timescale 1ns/1ps

module sb_tx_framer import sb_msg_pkg::*; (
    input  logic    clk_100MHz,
    input  logic    reset,
    input  sb_req_t req_i,
    input  logic    req_valid_i,
    input  logic    tx_ready_i,
    output logic    req_ready_o,
    output sb_msg_t tx_msg_o,
    output logic    tx_valid_o,
    output logic    msg_sent_o
);

    logic       accept;
    logic [7:0] tag_q;
    sb_msg_t    msg_next;

    // Free when empty or when the held message leaves this cycle
    assign req_ready_o = !tx_valid_o || tx_ready_i;
    assign accept      = req_valid_i && req_ready_o;
    assign msg_sent_o  = tx_valid_o && tx_ready_i;

    always_comb begin
        msg_next.opcode = req_i.opcode;
        msg_next.state  = req_i.state;
        msg_next.tag    = tag_q;
        msg_next.parity = sb_parity(req_i.opcode, req_i.state, tag_q);
    end

    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            tx_valid_o <= 1'b0;
            tag_q      <= 8'd0;
        end else begin
            if (accept) begin
                tx_valid_o <= 1'b1;
                // Wraps at 8 bits
                tag_q      <= tag_q + 8'd1;
            end else if (tx_ready_i) begin
                tx_valid_o <= 1'b0;
            end
        end
    end

    // Held stable until the transfer
    always_ff @(posedge clk_100MHz) begin
        if (accept) begin
            tx_msg_o <= msg_next;
        end
    end

endmodule

// ==== verilog/ltsm_sequencer.sv ====
`timescale 1ns/1ps

module ltsm_sequencer import ltsm_pkg::*, sb_msg_pkg::*; (
    input  logic        clk_100MHz,
    input  logic        reset,
    input  logic        enable_i,
    input  logic        start_training_i,
    input  logic        resp_valid_i,
    input  ltsm_state_t resp_state_i,
    input  logic        dwell_done_i,
    input  logic        state_timeout_i,
    input  logic        retry_due_i,
    input  logic        req_ready_i,
    input  logic        msg_sent_i,
    output ltsm_state_t state_o,
    output logic        state_change_o,
    output logic        rx_enable_o,
    output sb_req_t     req_o,
    output logic        req_valid_o,
    output logic        link_active_o
);

    ltsm_state_t state_q;
    ltsm_state_t state_next;
    logic        in_training;
    logic        resp_match;
    logic        entry;
    logic        req_owed;
    logic        in_flight;
    logic        load_req;
    logic        retry_fire;
    logic        err_sent;

    assign in_training = state_q inside {SBINIT, MBINIT, MBTRAIN, LINKINIT};
    assign resp_match  = resp_valid_i && (resp_state_i == state_q);

    // Error message has left the framer once nothing else is queued behind it
    assign err_sent = msg_sent_i && !req_valid_o && !req_owed;

    always_comb begin
        state_next = state_q;
        if (in_training && state_timeout_i) begin
            state_next = TRAINERROR;
        end else begin
            case (state_q)
                RESET: begin
                    if (dwell_done_i && enable_i && start_training_i) begin
                        state_next = SBINIT;
                    end
                end
                SBINIT:     state_next = resp_match ? MBINIT : SBINIT;
                MBINIT:     state_next = resp_match ? MBTRAIN : MBINIT;
                MBTRAIN:    state_next = resp_match ? LINKINIT : MBTRAIN;
                LINKINIT:   state_next = resp_match ? ACTIVE : LINKINIT;
                ACTIVE:     state_next = ACTIVE;
                TRAINERROR: state_next = err_sent ? RESET : TRAINERROR;
                default:    state_next = RESET;
            endcase
        end
    end

    assign state_change_o = (state_next != state_q);
    assign entry          = state_change_o && (state_next != RESET) && (state_next != ACTIVE);

    // Re-send only when nothing for this state is still on its way
    assign retry_fire = in_training && retry_due_i && !resp_match && !state_change_o &&
                        !req_owed && !req_valid_o && !in_flight;
    assign load_req   = req_owed && (!req_valid_o || req_ready_i) && !state_change_o;

    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            state_q     <= RESET;
            req_owed    <= 1'b0;
            req_valid_o <= 1'b0;
            in_flight   <= 1'b0;
        end else begin
            state_q <= state_next;

            if (state_change_o) begin
                req_owed <= entry;
            end else if (retry_fire) begin
                req_owed <= 1'b1;
            end else if (load_req) begin
                req_owed <= 1'b0;
            end

            if (load_req) begin
                req_valid_o <= 1'b1;
            end else if (req_ready_i) begin
                req_valid_o <= 1'b0;
            end

            // Framer holds at most one message
            if (req_valid_o && req_ready_i) begin
                in_flight <= 1'b1;
            end else if (msg_sent_i) begin
                in_flight <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_100MHz) begin
        if (load_req) begin
            req_o.opcode <= (state_q == TRAINERROR) ? SB_ERR : SB_REQ;
            req_o.state  <= state_q;
        end
    end

    assign state_o       = state_q;
    assign rx_enable_o   = (state_q != RESET);
    assign link_active_o = (state_q == ACTIVE);

endmodule

// ==== verilog/ltsm_timers.sv ====
`timescale 1ns/1ps

module ltsm_timers import ltsm_pkg::*; #(
    parameter int RESET_DWELL   = RESET_DWELL_DEFAULT,
    parameter int STATE_TIMEOUT = STATE_TIMEOUT_DEFAULT,
    parameter int RETRY         = RETRY_DEFAULT
) (
    input  logic        clk_100MHz,
    input  logic        reset,
    input  ltsm_state_t state_i,
    input  logic        state_change_i,
    input  logic        msg_sent_i,
    output logic        dwell_done_o,
    output logic        state_timeout_o,
    output logic        retry_due_o
);

    localparam int DWELL_W   = $clog2(RESET_DWELL + 1);
    localparam int TIMEOUT_W = $clog2(STATE_TIMEOUT + 1);
    localparam int RETRY_W   = $clog2(RETRY + 1);

    logic [DWELL_W-1:0]   dwell_cnt;
    logic [TIMEOUT_W-1:0] timeout_cnt;
    logic [RETRY_W-1:0]   retry_cnt;
    logic                 in_training;

    assign in_training = state_i inside {SBINIT, MBINIT, MBTRAIN, LINKINIT};

    assign dwell_done_o    = (dwell_cnt == DWELL_W'(RESET_DWELL));
    assign state_timeout_o = (timeout_cnt == TIMEOUT_W'(STATE_TIMEOUT));
    assign retry_due_o     = (retry_cnt == RETRY_W'(RETRY));

    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            dwell_cnt   <= '0;
            timeout_cnt <= '0;
            retry_cnt   <= '0;
        end else begin
            // Dwell counts only in RESET, then holds at its limit
            if (state_change_i) begin
                dwell_cnt <= '0;
            end else if (state_i == RESET && !dwell_done_o) begin
                dwell_cnt <= dwell_cnt + DWELL_W'(1);
            end

            // Per-state timeout for the four training states
            if (state_change_i) begin
                timeout_cnt <= '0;
            end else if (in_training && !state_timeout_o) begin
                timeout_cnt <= timeout_cnt + TIMEOUT_W'(1);
            end

            // Restarts only when a message actually leaves
            if (msg_sent_i) begin
                retry_cnt <= '0;
            end else if (!retry_due_o) begin
                retry_cnt <= retry_cnt + RETRY_W'(1);
            end
        end
    end

endmodule

// ==== verilog/sb_rx_decoder.sv ====
`timescale 1ns/1ps

module sb_rx_decoder import ltsm_pkg::*, sb_msg_pkg::*; (
    input  logic        clk_100MHz,
    input  logic        reset,
    input  logic        rx_enable_i,
    input  sb_msg_t     rx_msg_i,
    input  logic        rx_valid_i,
    output logic        rx_ready_o,
    output logic        resp_valid_o,
    output ltsm_state_t resp_state_o
);

    logic accept;
    logic parity_ok;
    logic is_resp;

    // No buffering, so ready simply follows enable
    assign rx_ready_o = rx_enable_i;
    assign accept     = rx_valid_i && rx_ready_o;

    assign parity_ok = (rx_msg_i.parity ==
                        sb_parity(rx_msg_i.opcode, rx_msg_i.state, rx_msg_i.tag));
    assign is_resp   = (rx_msg_i.opcode == SB_RESP);

    // One cycle response event
    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= accept && parity_ok && is_resp;
        end
    end

    // State field of the accepted message
    always_ff @(posedge clk_100MHz) begin
        if (accept) begin
            resp_state_o <= rx_msg_i.state;
        end
    end

endmodule

// ==== verilog/sb_msg_pkg.sv ====
package sb_msg_pkg;

    import ltsm_pkg::*;

    // Sideband message opcodes
    typedef enum logic [1:0] {
        SB_REQ  = 2'd0,
        SB_RESP = 2'd1,
        SB_ERR  = 2'd2
    } sb_opcode_t;

    // One whole sideband message, 14 bits
    typedef struct packed {
        sb_opcode_t  opcode;
        ltsm_state_t state;
        logic [7:0]  tag;
        logic        parity;
    } sb_msg_t;

    // Request from the state machine to the transmit side
    typedef struct packed {
        sb_opcode_t  opcode;
        ltsm_state_t state;
    } sb_req_t;

    // Even parity, all 14 message bits XOR to zero
    function automatic logic sb_parity(input sb_opcode_t  opcode,
                                       input ltsm_state_t state,
                                       input logic [7:0]  tag);
        return ^{opcode, state, tag};
    endfunction

endpackage

// ==== verilog/ltsm_pkg.sv ====
package ltsm_pkg;

    // Training state codes, 3'd6 is not used
    typedef enum logic [2:0] {
        RESET      = 3'd0,
        SBINIT     = 3'd1,
        MBINIT     = 3'd2,
        MBTRAIN    = 3'd3,
        LINKINIT   = 3'd4,
        ACTIVE     = 3'd5,
        TRAINERROR = 3'd7
    } ltsm_state_t;

    // Cycles spent in RESET before a start is honoured
    localparam int RESET_DWELL_DEFAULT = 100;

    // Cycles a training state may last before TRAINERROR
    localparam int STATE_TIMEOUT_DEFAULT = 2000;

    // Cycles between a sent request and its re-send
    localparam int RETRY_DEFAULT = 100;

endpackage
